// ==== source/rnn_defines.svh ====
`ifndef RNN_DEFINES_SVH
`define RNN_DEFINES_SVH

// network dimensions
`define RNN_VOCAB_SIZE   76            // tokens in the vocabulary
`define RNN_EMBED_SIZE   4             // elements per embedding vector
`define RNN_HIDDEN_SIZE  8             // hidden neurons

// number format, signed Q8.8
`define RNN_FRAC_BITS    8             // fraction bits
`define RNN_DATA_WIDTH   16            // one weight-memory word
`define RNN_ADDR_WIDTH   16            // word address width

// Weight memory map. The tables sit back to back in this order,
// each one indexed as described next to its base.
`define RNN_EMBED_BASE   0                                                // token*E + e
`define RNN_W_IH_BASE    (`RNN_EMBED_BASE + `RNN_VOCAB_SIZE * `RNN_EMBED_SIZE)  // j*E + e
`define RNN_W_HH_BASE    (`RNN_W_IH_BASE + `RNN_HIDDEN_SIZE * `RNN_EMBED_SIZE)  // j*H + k
`define RNN_B_IH_BASE    (`RNN_W_HH_BASE + `RNN_HIDDEN_SIZE * `RNN_HIDDEN_SIZE) // j
`define RNN_B_HH_BASE    (`RNN_B_IH_BASE + `RNN_HIDDEN_SIZE)                    // j

`endif

// ==== source/rnn_pkg.sv ====
`default_nettype none

`include "rnn_defines.svh"

package rnn_pkg;

    // signed Q8.8 value, one memory word
    typedef logic signed [`RNN_DATA_WIDTH-1:0] fixed_t;

    typedef logic [`RNN_ADDR_WIDTH-1:0] word_addr_t;        // weight memory word address

    typedef logic [$clog2(`RNN_VOCAB_SIZE)-1:0] token_t;    // 7 bits for 76 tokens

    // hidden state, neuron 0 in the low word
    typedef fixed_t [`RNN_HIDDEN_SIZE-1:0] hidden_vec_t;

    // wishbone classic master side, reads only
    typedef struct packed {
        logic       cyc;
        logic       stb;
        word_addr_t adr;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        fixed_t dat;                                         // valid while ack is high
    } wb_rsp_t;

    // one operation for the MAC
    typedef struct packed {
        logic   valid;
        logic   clear;                                       // load a, first term of a neuron
        logic   bias;                                        // add a unscaled
        fixed_t a;
        fixed_t b;
    } mac_op_t;

endpackage

`default_nettype wire

// ==== source/weight_fetch.sv ====
`default_nettype none

module weight_fetch
    import rnn_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        fetch_req,
    input  word_addr_t fetch_addr,
    input  wb_rsp_t    wb_rsp,
    output wb_req_t    wb_req,
    output logic       fetch_valid,
    output fixed_t     fetch_data
);

    logic       active;                       // bus cycle in progress
    word_addr_t adr_q;
    logic       valid_q;
    fixed_t     data_q;

    // two states: idle (active low) and waiting for ack (active high)
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active  <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;                  // single cycle pulse
            if (!active)
            begin
                if (fetch_req)
                    active <= 1'b1;           // cyc/stb up one cycle after the request
            end
            else if (wb_rsp.ack)
            begin
                active  <= 1'b0;              // drop cyc/stb right after ack
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!active && fetch_req)
            adr_q <= fetch_addr;              // held for the whole cycle
        if (active && wb_rsp.ack)
            data_q <= wb_rsp.dat;
    end

    assign wb_req      = '{cyc: active, stb: active, adr: adr_q};
    assign fetch_valid = valid_q;
    assign fetch_data  = data_q;

    // one word per bus cycle, cyc and stb fall together after the ack
    a_drop_after_ack : assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && wb_rsp.ack |=> !wb_req.cyc && !wb_req.stb);

    // the slave may stall as long as it likes, the request must not move
    a_adr_stable : assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

`default_nettype wire

// ==== source/mac_unit.sv ====
`default_nettype none

`include "rnn_defines.svh"

module mac_unit
    import rnn_pkg::*;
(
    input  wire     clk,
    input  wire     reset,
    input  mac_op_t mac_op,
    output fixed_t  acc_relu
);

    localparam int W = `RNN_DATA_WIDTH;

    logic signed [2*W-1:0] product_full;      // exact signed product
    fixed_t                product;
    fixed_t                acc;

    // Q8.8 times Q8.8 gives Q16.16, shift back and keep the low word
    assign product_full = $signed(mac_op.a) * $signed(mac_op.b);
    assign product      = fixed_t'(product_full >>> `RNN_FRAC_BITS);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            acc <= '0;
        end
        else if (mac_op.valid)
        begin
            if (mac_op.clear)
                acc <= mac_op.a;              // start of a new neuron
            else if (mac_op.bias)
                acc <= acc + mac_op.a;        // bias terms are already Q8.8
            else
                acc <= acc + product;         // wraps in 16 bits
        end
    end

    // relu, negative sums read as zero
    assign acc_relu = acc[W-1] ? fixed_t'(0) : acc;

    a_op_kind : assert property (@(posedge clk) disable iff (reset)
        mac_op.valid |-> !(mac_op.clear && mac_op.bias));

endmodule

`default_nettype wire

// ==== source/rnn_sequencer.sv ====
`default_nettype none

`include "rnn_defines.svh"

module rnn_sequencer
    import rnn_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         start,
    input  wire         clear,
    input  token_t      token,
    input  wire         fetch_valid,
    input  fixed_t      fetch_data,
    input  fixed_t      acc_relu,
    output logic        fetch_req,
    output word_addr_t  fetch_addr,
    output mac_op_t     mac_op,
    output logic        busy,
    output logic        done,
    output hidden_vec_t hidden
);

    localparam int E         = `RNN_EMBED_SIZE;
    localparam int H         = `RNN_HIDDEN_SIZE;
    localparam int MAX_LEN   = (E > H) ? E : H;
    localparam int CNT_W     = $clog2(MAX_LEN);
    localparam int EMB_IDX_W = $clog2(E);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_EMBED  = 3'd1;   // load token embedding
    localparam logic [2:0] S_IH     = 3'd2;   // input-to-hidden weights
    localparam logic [2:0] S_HH     = 3'd3;   // hidden-to-hidden weights
    localparam logic [2:0] S_BIH    = 3'd4;
    localparam logic [2:0] S_BHH    = 3'd5;
    localparam logic [2:0] S_SAMPLE = 3'd6;   // accumulator settled, take relu
    localparam logic [2:0] S_COMMIT = 3'd7;

    logic [2:0]         state;
    logic [CNT_W-1:0]   elem_cnt;             // element within the current run
    logic [CNT_W-1:0]   neuron_cnt;
    logic               elem_last;
    logic               neuron_last;
    token_t             token_q;
    fixed_t [E-1:0]     embed_q;
    hidden_vec_t        new_state_q;

    assign busy = (state != S_IDLE);

    // the hidden-to-hidden run is H long, the others E long
    assign elem_last   = (state == S_HH) ? (elem_cnt == CNT_W'(H - 1))
                                         : (elem_cnt == CNT_W'(E - 1));
    assign neuron_last = (neuron_cnt == CNT_W'(H - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_IDLE;
            elem_cnt   <= '0;
            neuron_cnt <= '0;
            fetch_req  <= 1'b0;
            done       <= 1'b0;
            hidden     <= '0;
        end
        else
        begin
            fetch_req <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (clear)
                        hidden <= '0;
                    if (start)
                    begin
                        state      <= S_EMBED;
                        elem_cnt   <= '0;
                        neuron_cnt <= '0;
                        fetch_req  <= 1'b1;
                    end
                end
                S_EMBED, S_IH, S_HH:
                begin
                    if (fetch_valid)
                    begin
                        fetch_req <= 1'b1;            // next word, counters move with it
                        if (elem_last)
                        begin
                            elem_cnt <= '0;
                            if (state == S_EMBED)
                                state <= S_IH;
                            else if (state == S_IH)
                                state <= S_HH;
                            else
                                state <= S_BIH;
                        end
                        else
                        begin
                            elem_cnt <= elem_cnt + 1'b1;
                        end
                    end
                end
                S_BIH:
                begin
                    if (fetch_valid)
                    begin
                        fetch_req <= 1'b1;
                        state     <= S_BHH;
                    end
                end
                S_BHH:
                begin
                    if (fetch_valid)
                        state <= S_SAMPLE;            // last op of the neuron goes out now
                end
                S_SAMPLE:
                begin
                    if (neuron_last)
                    begin
                        state <= S_COMMIT;
                    end
                    else
                    begin
                        neuron_cnt <= neuron_cnt + 1'b1;
                        state      <= S_IH;
                        fetch_req  <= 1'b1;
                    end
                end
                default:                               // S_COMMIT
                begin
                    hidden <= new_state_q;
                    done   <= 1'b1;
                    state  <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && start)
            token_q <= token;
        if (state == S_EMBED && fetch_valid)
            embed_q[elem_cnt[EMB_IDX_W-1:0]] <= fetch_data;
        if (state == S_SAMPLE)
            new_state_q[neuron_cnt] <= acc_relu;
    end

    // every fetched weight or bias turns into one MAC operation
    always_comb
    begin
        mac_op.valid = fetch_valid && (state inside {S_IH, S_HH, S_BIH, S_BHH});
        mac_op.clear = (state == S_IH) && (elem_cnt == '0);
        mac_op.bias  = (state == S_BIH) || (state == S_BHH);
        mac_op.a     = fetch_data;
        mac_op.b     = (state == S_HH) ? hidden[elem_cnt]
                                       : embed_q[elem_cnt[EMB_IDX_W-1:0]];
    end

    always_comb
    begin
        case (state)
            S_EMBED: fetch_addr = word_addr_t'(`RNN_EMBED_BASE + token_q * E + elem_cnt);
            S_IH:    fetch_addr = word_addr_t'(`RNN_W_IH_BASE + neuron_cnt * E + elem_cnt);
            S_HH:    fetch_addr = word_addr_t'(`RNN_W_HH_BASE + neuron_cnt * H + elem_cnt);
            S_BIH:   fetch_addr = word_addr_t'(`RNN_B_IH_BASE + neuron_cnt);
            S_BHH:   fetch_addr = word_addr_t'(`RNN_B_HH_BASE + neuron_cnt);
            default: fetch_addr = '0;
        endcase
    end

    // done only marks the cycle in which busy has just fallen
    a_done_idle : assert property (@(posedge clk) disable iff (reset)
        done |-> !busy && $past(busy));

endmodule

`default_nettype wire

// ==== source/rnn_cell_top.sv ====
`default_nettype none

module rnn_cell_top
    import rnn_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         start,
    input  wire         clear,
    input  token_t      token,
    input  wb_rsp_t     wb_rsp,
    output logic        busy,
    output logic        done,
    output hidden_vec_t hidden,
    output wb_req_t     wb_req
);

    logic       fetch_req;
    word_addr_t fetch_addr;
    logic       fetch_valid;
    fixed_t     fetch_data;
    mac_op_t    mac_op;
    fixed_t     acc_relu;

    rnn_sequencer u_rnn_sequencer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .clear       (clear),
        .token       (token),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .acc_relu    (acc_relu),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .mac_op      (mac_op),
        .busy        (busy),
        .done        (done),
        .hidden      (hidden)
    );

    // single-word reads from the weight memory
    weight_fetch u_weight_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .wb_rsp      (wb_rsp),
        .wb_req      (wb_req),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data)
    );

    mac_unit u_mac_unit (
        .clk         (clk),
        .reset       (reset),
        .mac_op      (mac_op),
        .acc_relu    (acc_relu)
    );

endmodule

`default_nettype wire

// ==== test/wb_weight_memory.sv ====
`default_nettype none

`include "rnn_defines.svh"

module wb_weight_memory
    import rnn_pkg::*;
(
    input  wire     clk,
    input  wire     reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = `RNN_B_HH_BASE + `RNN_HIDDEN_SIZE;    // end of the last table
    localparam int IDX_W = $clog2(DEPTH);

    fixed_t      mem [0:DEPTH-1];             // loaded by the testbench
    logic [31:0] wait_seed;
    logic [1:0]  waits;
    logic [1:0]  wait_left;
    logic        pending;                     // read accepted, counting wait states
    logic        ack_q;
    fixed_t      dat_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // outside the tables the data is a pattern of the full address
    function automatic fixed_t read_word(input word_addr_t a);
        if (int'(a) < DEPTH)
            return mem[a[IDX_W-1:0]];
        return fixed_t'(a ^ 16'h5a5a);
    endfunction

    assign waits = wait_seed[17:16];          // 0 to 3 wait states per read

    always @(posedge clk)
    begin
        if (reset)
        begin
            wait_seed <= 32'd14;
            pending   <= 1'b0;
            ack_q     <= 1'b0;
        end
        else
        begin
            ack_q <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !ack_q)
            begin
                if (!pending)
                begin
                    wait_seed <= lcg_next(wait_seed);
                    if (waits == 2'd0)
                    begin
                        ack_q <= 1'b1;        // no extra wait
                        dat_q <= read_word(wb_req.adr);
                    end
                    else
                    begin
                        pending   <= 1'b1;
                        wait_left <= waits - 2'd1;
                    end
                end
                else if (wait_left != 2'd0)
                begin
                    wait_left <= wait_left - 2'd1;
                end
                else
                begin
                    pending <= 1'b0;
                    ack_q   <= 1'b1;
                    dat_q   <= read_word(wb_req.adr);
                end
            end
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== test/rnn_cell_tb.sv ====
`default_nettype none

`include "rnn_defines.svh"

module rnn_cell_tb
    import rnn_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int E              = `RNN_EMBED_SIZE;
    localparam int H              = `RNN_HIDDEN_SIZE;
    localparam int MEM_DEPTH      = `RNN_B_HH_BASE + H;
    localparam int READS_PER_STEP = E + H * (E + H + 2);
    localparam int NUM_STEPS      = 5;
    // a read takes at most about 7 cycles, so 10 leaves room for the idle gaps
    localparam int TIMEOUT_CYCLES = NUM_STEPS * READS_PER_STEP * 10 + 200;

    logic        clk;
    logic        reset;
    logic        start;
    logic        clear;
    token_t      token;
    logic        busy;
    logic        done;
    hidden_vec_t hidden;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    fixed_t      image [0:MEM_DEPTH-1];       // copy of the weight memory for the model
    hidden_vec_t model_hidden;
    word_addr_t  addr_queue [$];              // addresses the coming reads must use
    logic [31:0] rand_state;
    int          error_count = 0;
    int          checks_run  = 0;
    int          cycle_count = 0;
    int          done_seen   = 0;
    int          reads_seen  = 0;

    rnn_cell_top u_rnn_cell_top (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .clear  (clear),
        .token  (token),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .done   (done),
        .hidden (hidden),
        .wb_req (wb_req)
    );

    wb_weight_memory u_wb_weight_memory (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (done)
            done_seen <= done_seen + 1;
        if (wb_rsp.ack)
        begin
            reads_seen <= reads_seen + 1;       // one ack per word read
            if (addr_queue.size() == 0)
            begin
                error_count++;
                $display("read from address %h while no read was expected", wb_req.adr);
            end
            else
            begin
                check_addr("wb adr", wb_req.adr, addr_queue.pop_front());
            end
        end
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Q8.8 product, full signed product shifted right by the fraction bits
    function automatic fixed_t q_mul(input fixed_t a, input fixed_t b);
        logic signed [31:0] p;
        p = a * b;
        return fixed_t'(p >>> `RNN_FRAC_BITS);
    endfunction

    function automatic hidden_vec_t model_step(input hidden_vec_t h_prev, input token_t tok);
        hidden_vec_t h_next;
        fixed_t      emb [E];
        fixed_t      sum;
        for (int e = 0; e < E; e++)
            emb[e] = image[`RNN_EMBED_BASE + int'(tok) * E + e];
        for (int j = 0; j < H; j++)
        begin
            sum = '0;
            for (int e = 0; e < E; e++)
                sum = sum + q_mul(image[`RNN_W_IH_BASE + j * E + e], emb[e]);
            for (int k = 0; k < H; k++)
                sum = sum + q_mul(image[`RNN_W_HH_BASE + j * H + k], h_prev[k]);
            sum = sum + image[`RNN_B_IH_BASE + j] + image[`RNN_B_HH_BASE + j];
            h_next[j] = (sum < 0) ? fixed_t'(0) : sum;    // relu
        end
        return h_next;
    endfunction

    // read order of one step: embedding, then per neuron weights and biases
    task automatic expect_addresses(input token_t tok);
        for (int e = 0; e < E; e++)
            addr_queue.push_back(word_addr_t'(`RNN_EMBED_BASE + int'(tok) * E + e));
        for (int j = 0; j < H; j++)
        begin
            for (int e = 0; e < E; e++)
                addr_queue.push_back(word_addr_t'(`RNN_W_IH_BASE + j * E + e));
            for (int k = 0; k < H; k++)
                addr_queue.push_back(word_addr_t'(`RNN_W_HH_BASE + j * H + k));
            addr_queue.push_back(word_addr_t'(`RNN_B_IH_BASE + j));
            addr_queue.push_back(word_addr_t'(`RNN_B_HH_BASE + j));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks_run++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_fixed(input string name, input fixed_t got, input fixed_t exp);
        checks_run++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input word_addr_t got,
                              input word_addr_t exp);
        checks_run++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_hidden(input string name, input hidden_vec_t got,
                                input hidden_vec_t exp);
        checks_run++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks_run++;
        if (got != exp)
        begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_word(input int addr, input fixed_t value);
        image[addr] = value;
        u_wb_weight_memory.mem[addr] = value;
    endtask

    // small values in [-1.0, 1.0); embedding element 0 is 1.0, since the
    // first term of a neuron is loaded into the MAC rather than multiplied
    task automatic load_memory();
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            rand_state = lcg_next(rand_state);
            write_word(a, fixed_t'(signed'(rand_state[24:16])));
        end
        for (int t = 0; t < `RNN_VOCAB_SIZE; t++)
            write_word(`RNN_EMBED_BASE + t * E, 16'sh0100);
    endtask

    // one full step, optionally with a second start pulse while busy
    task automatic run_step(input token_t tok, input int stray_start_at);
        int   reads_start;
        int   dones_start;
        int   waited;
        logic busy_before;
        reads_start = reads_seen;
        dones_start = done_seen;
        waited      = 0;
        expect_addresses(tok);
        token       = tok;
        start       = 1'b1;
        next_cycle();
        start       = 1'b0;
        check_bit("busy", busy, 1'b1);
        busy_before = busy;
        while (!done)
        begin
            busy_before = busy;
            start = (waited == stray_start_at);
            next_cycle();
            waited++;
        end
        start = 1'b0;
        check_bit("busy before done", busy_before, 1'b1);
        check_bit("busy at done", busy, 1'b0);
        model_hidden = model_step(model_hidden, tok);
        check_hidden("hidden", hidden, model_hidden);
        check_count("reads per step", reads_seen - reads_start, READS_PER_STEP);
        next_cycle();
        check_bit("done after pulse", done, 1'b0);
        repeat (20) next_cycle();
        check_count("done pulses", done_seen - dones_start, 1);
        check_bit("busy after step", busy, 1'b0);
    endtask

    task automatic test_reset_state();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("wb cyc", wb_req.cyc, 1'b0);
        check_bit("wb stb", wb_req.stb, 1'b0);
        check_hidden("hidden after reset", hidden, '0);
    endtask

    task automatic test_relu_clamp();
        for (int j = 0; j < H; j++)
        begin
            // -64.0 in total on every third neuron, +4.0 on the rest
            write_word(`RNN_B_IH_BASE + j, (j % 3 == 1) ? 16'shE000 : 16'sh0200);
            write_word(`RNN_B_HH_BASE + j, (j % 3 == 1) ? 16'shE000 : 16'sh0200);
        end
        run_step(7'd17, -1);
        for (int j = 1; j < H; j += 3)
            check_fixed("clamped neuron", hidden[j], fixed_t'(0));
    endtask

    task automatic test_busy_start_and_clear();
        run_step(7'd63, 10);
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        check_hidden("hidden after clear", hidden, '0);
        model_hidden = '0;
        run_step(7'd30, -1);
    endtask

    initial
    begin
        reset        = 1'b1;
        start        = 1'b0;
        clear        = 1'b0;
        token        = '0;
        rand_state   = 32'd14;
        model_hidden = '0;
        load_memory();
        repeat (16) next_cycle();
        reset = 1'b0;
        test_reset_state();
        run_step(7'd5, -1);                   // first step from zero state
        run_step(7'd42, -1);                  // recurrence on the previous state
        test_relu_clamp();
        test_busy_start_and_clear();
        $display("checks: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/rnn_pkg.sv
source/weight_fetch.sv
source/mac_unit.sv
source/rnn_sequencer.sv
source/rnn_cell_top.sv
test/wb_weight_memory.sv
test/rnn_cell_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rnn_cell_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
